/* sources.f */
design/i2c_target_pkg.sv
design/i2c_line_filter.sv
design/i2c_byte_shifter.sv
design/i2c_protocol_engine.sv
design/i2c_register_bank.sv
design/i2c_config_target.sv
verif/i2c_config_target_tb.sv

/* verif/i2c_config_target_tb.sv */
`timescale 1ns/1ps

module i2c_config_target_tb;

    localparam logic [6:0] TARGET_ADDR = 7'h50;
    localparam logic [6:0] OTHER_ADDR  = 7'h23;
    // scl high and low phase in clocks, data moves mid low phase
    localparam int PHASE = 30;
    localparam int HALF  = PHASE / 2;
    // about 90 bytes of 540 clocks plus start and stop conditions
    localparam int MAX_CYCLES = 60000;

    logic        CLOCK;
    logic        RESET;
    logic        scl;
    logic        master_low;
    logic        rd_en;
    logic [2:0]  add_in;
    logic [15:0] dat_out;
    logic        mclk_speed;
    logic        idle_mode;
    logic [1:0]  mclk_mode;
    logic [4:0]  rows_delay;
    wire         sda;

    logic [15:0] shadow [4];
    logic [15:0] lfsr;
    int          cycle_count;
    int          check_count;
    int          error_count;
    int          test_checks;
    int          test_errors;

    // pending checks, compared by the checker process
    string       name_q [$];
    logic [15:0] exp_q [$];
    logic [15:0] act_q [$];
    string       cur_name;
    logic [15:0] cur_exp;
    logic [15:0] cur_act;

    pullup (sda);
    assign sda = master_low ? 1'b0 : 1'bz;

    i2c_config_target i_i2c_config_target (
        .CLOCK      (CLOCK),
        .RESET      (RESET),
        .scl        (scl),
        .sda        (sda),
        .rd_en      (rd_en),
        .add_in     (add_in),
        .dat_out    (dat_out),
        .mclk_speed (mclk_speed),
        .idle_mode  (idle_mode),
        .mclk_mode  (mclk_mode),
        .rows_delay (rows_delay)
    );

    initial
    begin
        CLOCK = 1'b0;
        forever
        begin
            #2 CLOCK = ~CLOCK;
        end
    end

    //////////////////////////////
    // reference model
    //////////////////////////////
    function automatic logic [7:0] expected_byte(input logic [7:0] addr);
        logic [15:0] word;
        word = shadow[addr[2:1]];
        if (addr < 8)
        begin
            // even address is the high byte
            return addr[0] ? word[7:0] : word[15:8];
        end
        else if (addr < 12)
        begin
            // identity bytes 0x10 to 0x40
            return 8'((addr - 8'd7) << 4);
        end
        return 8'hFF;
    endfunction

    function automatic logic [15:0] expected_word(input logic [2:0] idx);
        return (idx < 4) ? shadow[idx[1:0]] : 16'h0000;
    endfunction

    // writes above address 7 change nothing
    task automatic shadow_write(input logic [7:0] addr, input logic [7:0] data);
        if (addr < 8)
        begin
            if (addr[0])
            begin
                shadow[addr[2:1]][7:0] = data;
            end
            else
            begin
                shadow[addr[2:1]][15:8] = data;
            end
        end
    endtask

    function automatic logic [15:0] galois_step(input logic [15:0] state);
        return (state >> 1) ^ (state[0] ? 16'hB400 : 16'h0000);
    endfunction

    task automatic random_byte(output logic [7:0] value);
        for (int i = 0; i < 8; i++)
        begin
            lfsr  = galois_step(lfsr);
            value = {value[6:0], lfsr[0]};
        end
    endtask

    //////////////////////////////
    // master bus tasks
    //////////////////////////////
    task automatic wait_clocks(input int n);
        repeat (n) @(negedge CLOCK);
    endtask

    // all bus tasks start and end with scl low, except stop
    task automatic issue_start();
        wait_clocks(HALF);
        master_low = 1'b0;
        wait_clocks(HALF);
        scl = 1'b1;
        wait_clocks(HALF);
        master_low = 1'b1;
        wait_clocks(HALF);
        scl = 1'b0;
    endtask

    task automatic issue_stop();
        wait_clocks(HALF);
        master_low = 1'b1;
        wait_clocks(HALF);
        scl = 1'b1;
        wait_clocks(HALF);
        master_low = 1'b0;
        wait_clocks(HALF);
    endtask

    task automatic drive_bit(input logic b);
        wait_clocks(HALF);
        master_low = ~b;
        wait_clocks(HALF);
        scl = 1'b1;
        wait_clocks(PHASE);
        scl = 1'b0;
    endtask

    task automatic sample_bit(output logic b);
        wait_clocks(HALF);
        master_low = 1'b0;
        wait_clocks(HALF);
        scl = 1'b1;
        wait_clocks(HALF);
        b = sda;
        wait_clocks(HALF);
        scl = 1'b0;
    endtask

    task automatic send_byte(input logic [7:0] data, output logic ack);
        for (int i = 7; i >= 0; i--)
        begin
            drive_bit(data[i]);
        end
        sample_bit(ack);
    endtask

    // single byte read, ends with a master nack
    task automatic receive_byte(output logic [7:0] data);
        logic b;
        for (int i = 0; i < 8; i++)
        begin
            sample_bit(b);
            data = {data[6:0], b};
        end
        drive_bit(1'b1);
    endtask

    //////////////////////////////
    // transactions and checks
    //////////////////////////////
    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        name_q.push_back(name);
        exp_q.push_back(expected);
        act_q.push_back(actual);
    endtask

    task automatic write_register(input logic [6:0] dev, input logic [7:0] addr,
                                  input logic [7:0] data, input logic acked);
        logic ack;
        logic exp_ack;
        // sda reads low on an acknowledge
        exp_ack = ~acked;
        issue_start();
        send_byte({dev, 1'b0}, ack);
        check_value("ack after control byte", exp_ack, ack);
        send_byte(addr, ack);
        check_value("ack after register address", exp_ack, ack);
        send_byte(data, ack);
        check_value("ack after write data", exp_ack, ack);
        issue_stop();
    endtask

    // address byte alone, then a repeated start with a read
    task automatic read_register(input logic [7:0] addr);
        logic       ack;
        logic [7:0] data;
        issue_start();
        send_byte({TARGET_ADDR, 1'b0}, ack);
        check_value("ack after control byte", 1'b0, ack);
        send_byte(addr, ack);
        check_value("ack after register address", 1'b0, ack);
        issue_start();
        send_byte({TARGET_ADDR, 1'b1}, ack);
        check_value("ack after read control byte", 1'b0, ack);
        receive_byte(data);
        issue_stop();
        check_value($sformatf("read data at %0d", addr), expected_byte(addr), data);
    endtask

    task automatic check_host_word(input logic [2:0] idx);
        @(negedge CLOCK);
        rd_en  = 1'b1;
        add_in = idx;
        @(negedge CLOCK);
        rd_en = 1'b0;
        check_value($sformatf("dat_out[%0d]", idx), expected_word(idx), dat_out);
    endtask

    task automatic check_all_words();
        for (int i = 0; i < 4; i++)
        begin
            check_host_word(3'(i));
        end
    endtask

    task automatic check_fields();
        check_value("mclk_speed", shadow[1][0], mclk_speed);
        check_value("idle_mode", shadow[1][1], idle_mode);
        check_value("mclk_mode", shadow[1][7:6], mclk_mode);
        check_value("rows_delay", shadow[1][15:11], rows_delay);
    endtask

    task automatic report_test(input int num, input string name);
        @(negedge CLOCK);
        $display("test %0d %s: %0d checks, %0d errors", num, name,
                 check_count - test_checks, error_count - test_errors);
        test_checks = check_count;
        test_errors = error_count;
    endtask

    // compare on the rising edge, after the falling edge pushes
    always @(posedge CLOCK)
    begin
        while (exp_q.size() > 0)
        begin
            cur_name = name_q.pop_front();
            cur_exp  = exp_q.pop_front();
            cur_act  = act_q.pop_front();
            check_count++;
            if (cur_act !== cur_exp)
            begin
                error_count++;
                $display("ERROR t=%0t %s expected=%h actual=%h",
                         $time, cur_name, cur_exp, cur_act);
            end
        end
    end

    always @(posedge CLOCK)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("timeout: run did not end within %0d clocks", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    //////////////////////////////
    // tests
    //////////////////////////////
    initial
    begin
        logic [7:0] data;
        logic       ack;
        RESET       = 1'b1;
        scl         = 1'b1;
        master_low  = 1'b0;
        rd_en       = 1'b0;
        add_in      = 3'd0;
        lfsr        = 16'd25732;
        cycle_count = 0;
        check_count = 0;
        error_count = 0;
        test_checks = 0;
        test_errors = 0;
        shadow[0]   = 16'h8095;
        shadow[1]   = 16'h031D;
        shadow[2]   = 16'h0000;
        shadow[3]   = 16'h0000;
        repeat (2) @(negedge CLOCK);
        RESET = 1'b0;
        wait_clocks(PHASE);

        check_all_words();
        check_host_word(3'd5);
        check_fields();
        report_test(1, "reset values");

        for (int a = 0; a < 8; a++)
        begin
            random_byte(data);
            write_register(TARGET_ADDR, 8'(a), data, 1'b1);
            shadow_write(8'(a), data);
        end
        check_all_words();
        check_fields();
        report_test(2, "random writes");

        for (int a = 0; a < 12; a++)
        begin
            read_register(8'(a));
        end
        read_register(8'd20);
        report_test(3, "bus reads");

        // foreign address, control byte alone then a full write
        issue_start();
        send_byte({OTHER_ADDR, 1'b0}, ack);
        check_value("ack for foreign address", 1'b1, ack);
        issue_stop();
        write_register(OTHER_ADDR, 8'd2, 8'hA5, 1'b0);
        check_all_words();
        report_test(4, "foreign address");

        random_byte(data);
        write_register(TARGET_ADDR, 8'd9, data, 1'b1);
        shadow_write(8'd9, data);
        random_byte(data);
        write_register(TARGET_ADDR, 8'd30, data, 1'b1);
        shadow_write(8'd30, data);
        check_all_words();
        read_register(8'd9);
        report_test(5, "unmapped writes");

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* design/i2c_config_target.sv */
`timescale 1ns/1ps

module i2c_config_target
    import i2c_target_pkg::*;
#(
    parameter logic [6:0] TARGET_ADDR  = 7'h50,
    parameter int         DEBOUNCE_LEN = 10
)
(
    input  logic         CLOCK,
    input  logic         RESET,
    input  logic         scl,
    inout  wire          sda,
    input  logic         rd_en,
    input  host_addr_t   add_in,
    output config_word_t dat_out,
    output logic         mclk_speed,
    output logic         idle_mode,
    output logic [1:0]   mclk_mode,
    output logic [4:0]   rows_delay
);

    logic      sda_level;
    logic      scl_rise;
    logic      scl_fall;
    logic      start_seen;
    logic      stop_seen;
    logic      rx_go;
    logic      tx_go;
    byte_t     rx_byte;
    byte_t     tx_byte;
    logic      ack_enable;
    logic      bits_done;
    logic      byte_done;
    logic      sda_pull_low;
    logic      acc_req;
    logic      acc_write;
    logic      acc_ack;
    reg_addr_t acc_addr;
    byte_t     acc_wdata;
    byte_t     acc_rdata;

    // open-drain pad, external pull-up gives the high level
    assign sda = sda_pull_low ? 1'b0 : 1'bz;

    i2c_line_filter #(
        .DEBOUNCE_LEN (DEBOUNCE_LEN)
    ) i_i2c_line_filter (
        .CLOCK      (CLOCK),
        .RESET      (RESET),
        .scl        (scl),
        .sda        (sda),
        .sda_level  (sda_level),
        .scl_rise   (scl_rise),
        .scl_fall   (scl_fall),
        .start_seen (start_seen),
        .stop_seen  (stop_seen)
    );

    i2c_byte_shifter i_i2c_byte_shifter (
        .CLOCK        (CLOCK),
        .RESET        (RESET),
        .scl_rise     (scl_rise),
        .scl_fall     (scl_fall),
        .sda_level    (sda_level),
        .rx_go        (rx_go),
        .tx_go        (tx_go),
        .tx_byte      (tx_byte),
        .ack_enable   (ack_enable),
        .rx_byte      (rx_byte),
        .bits_done    (bits_done),
        .byte_done    (byte_done),
        .sda_pull_low (sda_pull_low)
    );

    i2c_protocol_engine #(
        .TARGET_ADDR (TARGET_ADDR)
    ) i_i2c_protocol_engine (
        .CLOCK      (CLOCK),
        .RESET      (RESET),
        .start_seen (start_seen),
        .stop_seen  (stop_seen),
        .rx_byte    (rx_byte),
        .bits_done  (bits_done),
        .byte_done  (byte_done),
        .acc_ack    (acc_ack),
        .acc_rdata  (acc_rdata),
        .rx_go      (rx_go),
        .tx_go      (tx_go),
        .tx_byte    (tx_byte),
        .ack_enable (ack_enable),
        .acc_req    (acc_req),
        .acc_write  (acc_write),
        .acc_addr   (acc_addr),
        .acc_wdata  (acc_wdata)
    );

    i2c_register_bank i_i2c_register_bank (
        .CLOCK      (CLOCK),
        .RESET      (RESET),
        .acc_req    (acc_req),
        .acc_write  (acc_write),
        .acc_addr   (acc_addr),
        .acc_wdata  (acc_wdata),
        .rd_en      (rd_en),
        .add_in     (add_in),
        .acc_ack    (acc_ack),
        .acc_rdata  (acc_rdata),
        .dat_out    (dat_out),
        .mclk_speed (mclk_speed),
        .idle_mode  (idle_mode),
        .mclk_mode  (mclk_mode),
        .rows_delay (rows_delay)
    );

endmodule

/* design/i2c_register_bank.sv */
`timescale 1ns/1ps

module i2c_register_bank
    import i2c_target_pkg::*;
(
    input  logic         CLOCK,
    input  logic         RESET,
    input  logic         acc_req,
    input  logic         acc_write,
    input  reg_addr_t    acc_addr,
    input  byte_t        acc_wdata,
    input  logic         rd_en,
    input  host_addr_t   add_in,
    output logic         acc_ack,
    output byte_t        acc_rdata,
    output config_word_t dat_out,
    output logic         mclk_speed,
    output logic         idle_mode,
    output logic [1:0]   mclk_mode,
    output logic [4:0]   rows_delay
);

    localparam int WORD_IDX_W = $clog2(CONFIG_WORDS);
    localparam int ID_IDX_W   = $clog2(ID_COUNT);
    // word holding the decoded fields
    localparam int FIELD_WORD = 1;

    config_word_t          words [CONFIG_WORDS];
    logic                  access;
    logic                  in_config;
    logic                  in_id;
    logic [WORD_IDX_W-1:0] word_idx;
    logic [ID_IDX_W-1:0]   id_idx;
    byte_t                 read_value;

    // first cycle of a request, before the ack goes up
    assign access    = acc_req & ~acc_ack;
    assign in_config = (acc_addr < 2 * CONFIG_WORDS);
    assign in_id     = (acc_addr >= ID_BASE) && (acc_addr < ID_BASE + ID_COUNT);
    assign word_idx  = acc_addr[WORD_IDX_W:1];
    assign id_idx    = ID_IDX_W'(acc_addr - ID_BASE);

    // even address is the high byte
    always_comb
    begin
        if (in_config)
        begin
            read_value = acc_addr[0] ? words[word_idx][7:0] : words[word_idx][15:8];
        end
        else if (in_id)
        begin
            read_value = ID_BYTES[id_idx];
        end
        else
        begin
            read_value = UNMAPPED_READ;
        end
    end

    //////////////////////////////
    // bus access port
    //////////////////////////////
    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            for (int i = 0; i < CONFIG_WORDS; i++)
            begin
                words[i] <= CONFIG_RESET[i];
            end
        end
        else if (access && acc_write && in_config)
        begin
            if (acc_addr[0])
            begin
                words[word_idx][7:0] <= acc_wdata;
            end
            else
            begin
                words[word_idx][15:8] <= acc_wdata;
            end
        end
    end

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            acc_ack <= 1'b0;
        end
        else
        begin
            acc_ack <= acc_req;
        end
    end

    always_ff @(posedge CLOCK)
    begin
        if (access && !acc_write)
        begin
            acc_rdata <= read_value;
        end
    end

    //////////////////////////////
    // host read port
    //////////////////////////////
    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            dat_out <= '0;
        end
        else if (rd_en)
        begin
            dat_out <= (add_in < CONFIG_WORDS) ? words[add_in[WORD_IDX_W-1:0]] : '0;
        end
    end

    // field decode
    assign mclk_speed = words[FIELD_WORD][0];
    assign idle_mode  = words[FIELD_WORD][1];
    assign mclk_mode  = words[FIELD_WORD][7:6];
    assign rows_delay = words[FIELD_WORD][15:11];

    // four-phase rule, a request from the engine is held until acked
    assert property (@(posedge CLOCK) disable iff (RESET)
        acc_req && !acc_ack |=> acc_req);

endmodule

/* design/i2c_protocol_engine.sv */
`timescale 1ns/1ps

module i2c_protocol_engine
    import i2c_target_pkg::*;
#(
    parameter logic [6:0] TARGET_ADDR = 7'h50
)
(
    input  logic      CLOCK,
    input  logic      RESET,
    input  logic      start_seen,
    input  logic      stop_seen,
    input  byte_t     rx_byte,
    input  logic      bits_done,
    input  logic      byte_done,
    input  logic      acc_ack,
    input  byte_t     acc_rdata,
    output logic      rx_go,
    output logic      tx_go,
    output byte_t     tx_byte,
    output logic      ack_enable,
    output logic      acc_req,
    output logic      acc_write,
    output reg_addr_t acc_addr,
    output byte_t     acc_wdata
);

    engine_state_e state;
    logic          addr_match;

    assign addr_match = (rx_byte[7:1] == TARGET_ADDR);

    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            state      <= EN_IDLE;
            rx_go      <= 1'b0;
            tx_go      <= 1'b0;
            ack_enable <= 1'b0;
            acc_req    <= 1'b0;
            acc_write  <= 1'b0;
            acc_addr   <= '0;
        end
        else
        begin
            rx_go <= 1'b0;
            tx_go <= 1'b0;
            // req drops on ack whatever the bus does meanwhile
            if (acc_req && acc_ack)
            begin
                acc_req <= 1'b0;
            end

            if (start_seen)
            begin
                state      <= EN_CONTROL;
                rx_go      <= 1'b1;
                ack_enable <= 1'b0;
            end
            else if (stop_seen)
            begin
                state      <= EN_IDLE;
                ack_enable <= 1'b0;
            end
            else
            begin
                case (state)
                    EN_CONTROL:
                    begin
                        if (bits_done)
                        begin
                            ack_enable <= addr_match;
                        end
                        if (byte_done)
                        begin
                            ack_enable <= 1'b0;
                            if (!ack_enable)
                            begin
                                state <= EN_IDLE;
                            end
                            else if (rx_byte[0])
                            begin
                                // read from the address stored by the last write
                                state     <= EN_READ_ACCESS;
                                acc_req   <= 1'b1;
                                acc_write <= 1'b0;
                            end
                            else
                            begin
                                state <= EN_REG_ADDR;
                                rx_go <= 1'b1;
                            end
                        end
                    end
                    EN_REG_ADDR:
                    begin
                        if (bits_done)
                        begin
                            ack_enable <= 1'b1;
                        end
                        if (byte_done)
                        begin
                            ack_enable <= 1'b0;
                            acc_addr   <= rx_byte;
                            state      <= EN_WRITE_DATA;
                            rx_go      <= 1'b1;
                        end
                    end
                    EN_WRITE_DATA:
                    begin
                        if (bits_done)
                        begin
                            ack_enable <= 1'b1;
                        end
                        if (byte_done)
                        begin
                            ack_enable <= 1'b0;
                            acc_wdata  <= rx_byte;
                            acc_write  <= 1'b1;
                            acc_req    <= 1'b1;
                            state      <= EN_WRITE_ACCESS;
                        end
                    end
                    EN_WRITE_ACCESS:
                    begin
                        if (acc_ack)
                        begin
                            state <= EN_WAIT_STOP;
                        end
                    end
                    EN_READ_ACCESS:
                    begin
                        if (acc_req && acc_ack)
                        begin
                            tx_byte <= acc_rdata;
                            tx_go   <= 1'b1;
                            state   <= EN_READ_DATA;
                        end
                    end
                    EN_READ_DATA:
                    begin
                        // single byte read, master ack ignored
                        if (byte_done)
                        begin
                            state <= EN_WAIT_STOP;
                        end
                    end
                    default:
                    begin
                        // idle and wait stop only leave on start or stop
                    end
                endcase
            end
        end
    end

    // ack from the bank only ever answers a pending request
    assert property (@(posedge CLOCK) disable iff (RESET)
        $rose(acc_ack) |-> $past(acc_req));

endmodule

/* design/i2c_byte_shifter.sv */
`timescale 1ns/1ps

module i2c_byte_shifter
    import i2c_target_pkg::*;
(
    input  logic  CLOCK,
    input  logic  RESET,
    input  logic  scl_rise,
    input  logic  scl_fall,
    input  logic  sda_level,
    input  logic  rx_go,
    input  logic  tx_go,
    input  byte_t tx_byte,
    input  logic  ack_enable,
    output byte_t rx_byte,
    output logic  bits_done,
    output logic  byte_done,
    output logic  sda_pull_low
);

    shifter_state_e state;
    byte_t          shift_reg;
    logic [3:0]     bit_cnt;

    // received byte stays in the shift register until the next go
    assign rx_byte = shift_reg;

    //////////////////////////////
    // control
    //////////////////////////////
    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            state        <= SH_IDLE;
            bit_cnt      <= '0;
            bits_done    <= 1'b0;
            byte_done    <= 1'b0;
            sda_pull_low <= 1'b0;
        end
        else
        begin
            bits_done <= 1'b0;
            byte_done <= 1'b0;
            if (rx_go)
            begin
                state        <= SH_RECV;
                bit_cnt      <= '0;
                sda_pull_low <= 1'b0;
            end
            else if (tx_go)
            begin
                // msb goes on the line right away, scl is low here
                state        <= SH_SEND;
                bit_cnt      <= '0;
                sda_pull_low <= ~tx_byte[7];
            end
            else
            begin
                case (state)
                    SH_RECV:
                    begin
                        if (scl_rise && bit_cnt != 4'd8)
                        begin
                            bit_cnt   <= bit_cnt + 4'd1;
                            bits_done <= (bit_cnt == 4'd7);
                        end
                        else if (scl_fall && bit_cnt == 4'd8)
                        begin
                            // ack slot starts, engine decided by now
                            sda_pull_low <= ack_enable;
                            state        <= SH_ACK;
                        end
                    end
                    SH_ACK:
                    begin
                        if (scl_fall)
                        begin
                            sda_pull_low <= 1'b0;
                            byte_done    <= 1'b1;
                            state        <= SH_IDLE;
                        end
                    end
                    SH_SEND:
                    begin
                        if (scl_fall)
                        begin
                            if (bit_cnt == 4'd7)
                            begin
                                // bit 0 done, master owns the ack slot
                                sda_pull_low <= 1'b0;
                                byte_done    <= 1'b1;
                                state        <= SH_RELEASE;
                            end
                            else
                            begin
                                bit_cnt      <= bit_cnt + 4'd1;
                                sda_pull_low <= ~shift_reg[6];
                            end
                        end
                    end
                    SH_RELEASE:
                    begin
                        // end of the master ack slot
                        if (scl_fall)
                        begin
                            state <= SH_IDLE;
                        end
                    end
                    default:
                    begin
                        state <= SH_IDLE;
                    end
                endcase
            end
        end
    end

    //////////////////////////////
    // data path
    //////////////////////////////
    always_ff @(posedge CLOCK)
    begin
        if (tx_go)
        begin
            shift_reg <= tx_byte;
        end
        else if (state == SH_RECV && scl_rise && bit_cnt != 4'd8)
        begin
            shift_reg <= {shift_reg[6:0], sda_level};
        end
        else if (state == SH_SEND && scl_fall && bit_cnt != 4'd7)
        begin
            shift_reg <= {shift_reg[6:0], 1'b0};
        end
    end

    // line released whenever no byte is in progress
    assert property (@(posedge CLOCK) disable iff (RESET)
        state == SH_IDLE |-> !sda_pull_low);

endmodule

/* design/i2c_line_filter.sv */
`timescale 1ns/1ps

module i2c_line_filter #(
    parameter int DEBOUNCE_LEN = 10
)
(
    input  logic CLOCK,
    input  logic RESET,
    input  logic scl,
    input  logic sda,
    output logic sda_level,
    output logic scl_rise,
    output logic scl_fall,
    output logic start_seen,
    output logic stop_seen
);

    // line index inside the filter arrays
    localparam int SDA_IDX = 0;
    localparam int SCL_IDX = 1;

    logic [1:0]              raw_line;
    logic [DEBOUNCE_LEN-1:0] pipe [2];
    logic [1:0]              level;
    logic [1:0]              level_prev;

    assign raw_line  = {scl, sda};
    assign sda_level = level[SDA_IDX];

    //////////////////////////////
    // debounce
    //////////////////////////////
    // a held level only moves once every sample in its pipe agrees
    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            for (int i = 0; i < 2; i++)
            begin
                pipe[i] <= '1;
            end
            level      <= 2'b11;
            level_prev <= 2'b11;
        end
        else
        begin
            for (int i = 0; i < 2; i++)
            begin
                pipe[i] <= {pipe[i][DEBOUNCE_LEN-2:0], raw_line[i]};
                if (&pipe[i])
                begin
                    level[i] <= 1'b1;
                end
                else if (~|pipe[i])
                begin
                    level[i] <= 1'b0;
                end
            end
            level_prev <= level;
        end
    end

    //////////////////////////////
    // edge and condition events
    //////////////////////////////
    always_ff @(posedge CLOCK)
    begin
        if (RESET)
        begin
            scl_rise   <= 1'b0;
            scl_fall   <= 1'b0;
            start_seen <= 1'b0;
            stop_seen  <= 1'b0;
        end
        else
        begin
            scl_rise   <= level[SCL_IDX] & ~level_prev[SCL_IDX];
            scl_fall   <= ~level[SCL_IDX] & level_prev[SCL_IDX];
            // sda moving while scl stays high
            start_seen <= level[SCL_IDX] & level_prev[SCL_IDX]
                        & ~level[SDA_IDX] & level_prev[SDA_IDX];
            stop_seen  <= level[SCL_IDX] & level_prev[SCL_IDX]
                        & level[SDA_IDX] & ~level_prev[SDA_IDX];
        end
    end

endmodule

/* design/i2c_target_pkg.sv */
package i2c_target_pkg;

    // bus and register widths
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  reg_addr_t;
    typedef logic [15:0] config_word_t;
    typedef logic [2:0]  host_addr_t;

    //////////////////////////////
    // register map
    //////////////////////////////
    localparam int        CONFIG_WORDS = 4;
    localparam reg_addr_t ID_BASE      = 8'd8;
    localparam int        ID_COUNT     = 4;

    // identity bytes at addresses 8 to 11
    localparam byte_t ID_BYTES [ID_COUNT] = '{8'h10, 8'h20, 8'h30, 8'h40};

    localparam config_word_t CONFIG_RESET [CONFIG_WORDS] =
        '{16'h8095, 16'h031D, 16'h0000, 16'h0000};

    // any address above the identity bytes
    localparam byte_t UNMAPPED_READ = 8'hFF;

    //////////////////////////////
    // state machines
    //////////////////////////////
    typedef enum logic [2:0] {
        EN_IDLE,
        EN_CONTROL,
        EN_REG_ADDR,
        EN_WRITE_DATA,
        EN_WRITE_ACCESS,
        EN_READ_ACCESS,
        EN_READ_DATA,
        EN_WAIT_STOP
    } engine_state_e;

    typedef enum logic [2:0] {
        SH_IDLE,
        SH_RECV,
        SH_ACK,
        SH_SEND,
        SH_RELEASE
    } shifter_state_e;

endpackage
